/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = hangmanTb
FILELIST  = all.f
OBJDIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* all.f */
hw/hangmanPkg.sv
hw/wordStore.sv
hw/letterMatcher.sv
hw/guessHistory.sv
hw/gameController.sv
hw/hangmanTop.sv
tb/hangman_properties.sv
tb/hangmanTb.sv

/* hw/gameController.sv */
// Game FSM that accepts guesses, resolves them into reveals or mistakes and declares the outcome.

`timescale 1ns/1ns

module gameController (
    input  logic                 clk,
    input  logic                 nRst,
    input  logic                 startGame,
    input  logic                 guessValid,
    input  hangmanPkg::posMaskT  hitMask,
    input  logic                 matchDone,
    input  logic                 alreadyTried,
    output logic                 guessAccept,
    output logic                 newRound,
    output logic                 wordLoadEnable,
    output logic                 gameReady,
    output logic                 busy,
    output hangmanPkg::posMaskT  revealed,
    output hangmanPkg::countT    numCorrect,
    output hangmanPkg::countT    numMistake,
    output logic                 hit,
    output logic                 mistake,
    output logic                 guessRejected,
    output logic                 win,
    output logic                 lose
);

    hangmanPkg::gameStateT state;
    hangmanPkg::gameStateT stateNext;
    hangmanPkg::posMaskT   revealedNext;  // revealed with the current mask folded in.
    hangmanPkg::countT     mistakeNext;
    logic                  resolve;       // the cycle in which a guess is settled.
    logic                  isHit;

    function automatic hangmanPkg::countT popCount(input hangmanPkg::posMaskT mask);
        hangmanPkg::countT total;
        total = '0;
        for (int i = 0; i < hangmanPkg::wordLen; i++) begin
            total = total + hangmanPkg::countT'(mask[i]);
        end
        return total;
    endfunction

    // ####################################################################
    // strobes and status
    // ####################################################################

    assign guessAccept    = guessValid && (state == hangmanPkg::waitGuess);
    assign newRound       = startGame && ((state == hangmanPkg::idle) ||
                                          (state == hangmanPkg::won) ||
                                          (state == hangmanPkg::lost));
    assign wordLoadEnable = (state == hangmanPkg::idle);
    assign gameReady      = (state == hangmanPkg::idle) || (state == hangmanPkg::waitGuess);
    assign busy           = (state == hangmanPkg::matching) || (state == hangmanPkg::decide);
    assign win            = (state == hangmanPkg::won);
    assign lose           = (state == hangmanPkg::lost);

    assign resolve      = (state == hangmanPkg::decide) && matchDone;
    assign isHit        = !alreadyTried && (hitMask != '0);
    assign revealedNext = revealed | hitMask;
    assign mistakeNext  = numMistake + 3'd1;

    // ####################################################################
    // next state
    // ####################################################################

    always_comb begin
        stateNext = state;
        case (state)
            hangmanPkg::idle: begin
                if (startGame) stateNext = hangmanPkg::waitGuess;
            end
            hangmanPkg::waitGuess: begin
                if (guessValid) stateNext = hangmanPkg::matching;
            end
            // alreadyTried becomes valid after this cycle.
            hangmanPkg::matching: stateNext = hangmanPkg::decide;
            hangmanPkg::decide: begin
                if (matchDone) begin
                    stateNext = hangmanPkg::waitGuess;
                    if (alreadyTried) begin
                        stateNext = hangmanPkg::waitGuess;  // rejected, nothing moves.
                    end else if (isHit) begin
                        if (revealedNext == '1) stateNext = hangmanPkg::won;
                    end else if (mistakeNext == hangmanPkg::countT'(hangmanPkg::maxMistakes)) begin
                        stateNext = hangmanPkg::lost;
                    end
                end
            end
            hangmanPkg::won, hangmanPkg::lost: begin
                if (startGame) stateNext = hangmanPkg::waitGuess;
            end
            default: stateNext = hangmanPkg::idle;
        endcase
    end

    // ####################################################################
    // state, counters and outcome pulses
    // ####################################################################

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state         <= hangmanPkg::idle;
            revealed      <= '0;
            numCorrect    <= '0;
            numMistake    <= '0;
            hit           <= 1'b0;
            mistake       <= 1'b0;
            guessRejected <= 1'b0;
        end else begin
            state         <= stateNext;
            hit           <= 1'b0;
            mistake       <= 1'b0;
            guessRejected <= 1'b0;
            if (newRound) begin
                revealed   <= '0;
                numCorrect <= '0;
                numMistake <= '0;
            end else if (resolve) begin
                if (alreadyTried) begin
                    guessRejected <= 1'b1;
                end else if (isHit) begin
                    hit        <= 1'b1;
                    revealed   <= revealedNext;
                    numCorrect <= popCount(revealedNext); // repeated letters count per position.
                end else begin
                    mistake    <= 1'b1;
                    numMistake <= mistakeNext;
                end
            end
        end
    end

endmodule

/* hw/guessHistory.sv */
// Remembers which letters were tried in the current round and flags repeated or non-letter guesses.

`timescale 1ns/1ns

module guessHistory (
    input  logic               clk,
    input  logic               nRst,
    input  hangmanPkg::letterT guess,
    input  logic               guessAccept,
    input  logic               newRound,
    output logic               alreadyTried
);

    hangmanPkg::letterSetT tried;     // bit n set once letter A+n was guessed.
    hangmanPkg::letterT    offset;
    logic [4:0]            letterIdx;
    logic                  isLetter;

    always_comb begin
        isLetter  = (guess >= hangmanPkg::letterA) && (guess <= hangmanPkg::letterZ);
        offset    = guess - hangmanPkg::letterA;
        letterIdx = offset[4:0];      // only meaningful when isLetter is high.
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            tried        <= '0;
            alreadyTried <= 1'b0;
        end else if (newRound) begin
            tried        <= '0;
            alreadyTried <= 1'b0;
        end else if (guessAccept) begin
            // anything outside A to Z is treated as though it was tried before.
            alreadyTried <= !isLetter || tried[letterIdx];
            if (isLetter) begin
                tried[letterIdx] <= 1'b1;
            end
        end
    end

    // alreadyTried holds its value until the next accepted guess.

endmodule

/* hw/hangmanPkg.sv */
// Shared widths, game constants and controller states for the hangman core and its testbench.

package hangmanPkg;

    // ####################################################################
    // game constants
    // ####################################################################

    localparam int wordLen     = 5;  // letters in a secret word.
    localparam int maxMistakes = 6;  // a round is lost at this many misses.
    localparam int letterBits  = 8;  // one ASCII character per letter.
    localparam int wordBits    = wordLen * letterBits;

    // ####################################################################
    // vector types
    // ####################################################################

    typedef logic [letterBits-1:0] letterT;   // one ASCII letter.
    typedef logic [wordLen-1:0]    posMaskT;  // bit 4 is the first letter loaded.
    typedef logic [2:0]            countT;    // mistakes or correct positions.
    typedef logic [25:0]           letterSetT; // one bit per letter, bit 0 is A.

    // first and last capital letters, used to screen out non-letter guesses.
    localparam letterT letterA = 8'h41;
    localparam letterT letterZ = 8'h5A;

    // controller states.
    typedef enum logic [2:0] {
        idle,       // the word may be loaded.
        waitGuess,  // ready for the next guess.
        matching,   // the history is looking up the accepted guess.
        decide,     // waiting for the full hit mask, then resolving the guess.
        won,
        lost
    } gameStateT;

endpackage

/* hw/hangmanTop.sv */
// Top level of the hangman core, wiring the word store, matcher, history and controller together.

`timescale 1ns/1ns

module hangmanTop (
    input  logic                clk,
    input  logic                nRst,
    input  hangmanPkg::letterT  wordLetter,
    input  logic                wordLoad,
    input  logic                startGame,
    input  hangmanPkg::letterT  guess,
    input  logic                guessValid,
    output logic                gameReady,
    output logic                busy,
    output hangmanPkg::posMaskT revealed,
    output hangmanPkg::countT   numCorrect,
    output hangmanPkg::countT   numMistake,
    output logic                hit,
    output logic                mistake,
    output logic                guessRejected,
    output logic                win,
    output logic                lose
);

    logic [hangmanPkg::wordBits-1:0] storedWord;
    hangmanPkg::posMaskT             hitMask;
    logic                            matchDone;
    logic                            alreadyTried;
    logic                            guessAccept;   // one guess in flight at a time.
    logic                            newRound;
    logic                            wordLoadEnable;

    wordStore uWordStore (
        .clk            (clk),
        .nRst           (nRst),
        .wordLetter     (wordLetter),
        .wordLoad       (wordLoad),
        .wordLoadEnable (wordLoadEnable),
        .storedWord     (storedWord)
    );

    letterMatcher uLetterMatcher (
        .clk         (clk),
        .nRst        (nRst),
        .guess       (guess),
        .guessAccept (guessAccept),
        .storedWord  (storedWord),
        .hitMask     (hitMask),
        .matchDone   (matchDone)
    );

    guessHistory uGuessHistory (
        .clk          (clk),
        .nRst         (nRst),
        .guess        (guess),
        .guessAccept  (guessAccept),
        .newRound     (newRound),
        .alreadyTried (alreadyTried)
    );

    gameController uGameController (
        .clk            (clk),
        .nRst           (nRst),
        .startGame      (startGame),
        .guessValid     (guessValid),
        .hitMask        (hitMask),
        .matchDone      (matchDone),
        .alreadyTried   (alreadyTried),
        .guessAccept    (guessAccept),
        .newRound       (newRound),
        .wordLoadEnable (wordLoadEnable),
        .gameReady      (gameReady),
        .busy           (busy),
        .revealed       (revealed),
        .numCorrect     (numCorrect),
        .numMistake     (numMistake),
        .hit            (hit),
        .mistake        (mistake),
        .guessRejected  (guessRejected),
        .win            (win),
        .lose           (lose)
    );

endmodule

/* hw/letterMatcher.sv */
// Scans the stored word one position per cycle against an accepted guess and builds a hit mask.

`timescale 1ns/1ns

module letterMatcher (
    input  logic                                clk,
    input  logic                                nRst,
    input  hangmanPkg::letterT                  guess,
    input  logic                                guessAccept,
    input  logic [hangmanPkg::wordBits-1:0]     storedWord,
    output hangmanPkg::posMaskT                 hitMask,
    output logic                                matchDone
);

    localparam logic [2:0] lastPos = 3'(hangmanPkg::wordLen - 1);

    hangmanPkg::letterT guessReg;    // the letter under test, held for the scan.
    hangmanPkg::letterT posLetter;   // stored letter at the current position.
    logic [2:0]         posIdx;      // 0 is the first letter loaded.
    logic               scanning;
    logic               posHit;

    // ####################################################################
    // position select
    // ####################################################################

    // position 0 lives in the top byte of the word.
    always_comb begin
        posLetter = storedWord[(lastPos - posIdx) * hangmanPkg::letterBits
                               +: hangmanPkg::letterBits];
        posHit    = (posLetter == guessReg);
    end

    // the scan compares against this copy, so the guess input may change while busy.
    always_ff @(posedge clk) begin
        if (guessAccept) begin
            guessReg <= guess;
        end
    end

    // ####################################################################
    // scan control
    // ####################################################################

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            posIdx    <= '0;
            scanning  <= 1'b0;
            hitMask   <= '0;
            matchDone <= 1'b0;
        end else begin
            matchDone <= 1'b0; // a single-cycle pulse unless set below.
            if (guessAccept) begin
                posIdx   <= '0;
                scanning <= 1'b1;
                hitMask  <= '0;          // the old mask is dropped for the new guess.
            end else if (scanning) begin
                hitMask[lastPos - posIdx] <= posHit; // mask bit 4 is position 0.
                if (posIdx == lastPos) begin
                    scanning  <= 1'b0;
                    matchDone <= 1'b1;   // the mask is complete from this edge on.
                end else begin
                    posIdx <= posIdx + 3'd1;
                end
            end
        end
    end

endmodule

/* hw/wordStore.sv */
// Holds the secret word, shifted in one letter per load strobe while the game is idle.

`timescale 1ns/1ns

module wordStore (
    input  logic                                clk,
    input  logic                                nRst,
    input  hangmanPkg::letterT                  wordLetter,
    input  logic                                wordLoad,
    input  logic                                wordLoadEnable,
    output logic [hangmanPkg::wordBits-1:0]     storedWord
);

    logic shiftIn; // a load strobe that the controller allows.

    assign shiftIn = wordLoad && wordLoadEnable;

    // the first position sits in the top byte. Each load moves every letter
    // one place toward it and drops the new letter into the lowest byte, so the
    // register always holds the last five letters loaded.
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            storedWord <= '0;
        end else if (shiftIn) begin
            storedWord <= {storedWord[hangmanPkg::wordBits-hangmanPkg::letterBits-1:0],
                           wordLetter};
        end
    end

    // the word is kept across rounds; only a new load in idle replaces it.

endmodule

/* tb/hangmanTb.sv */
// Testbench for the hangman core; replays the stimulus file and checks every guess outcome.

`timescale 1ns/1ns

module hangmanTb;

    localparam int maxLines  = 64;
    localparam int fields    = 8;   // tokens per stimulus line.
    localparam int clkHalf   = 2;
    localparam int cmdLoad   = 0;
    localparam int cmdStart  = 1;
    localparam int cmdGuess  = 2;
    localparam int cmdNoisy  = 3;   // guess with random guesses injected while busy.
    localparam int cmdIgnore = 4;   // guess that must be dropped in won or lost.
    localparam int cmdEnd    = 15;

    logic                clk;
    logic                nRst;
    hangmanPkg::letterT  wordLetter;
    logic                wordLoad;
    logic                startGame;
    hangmanPkg::letterT  guess;
    logic                guessValid;
    logic                gameReady;
    logic                busy;
    hangmanPkg::posMaskT revealed;
    hangmanPkg::countT   numCorrect;
    hangmanPkg::countT   numMistake;
    logic                hit;
    logic                mistake;
    logic                guessRejected;
    logic                win;
    logic                lose;

    logic [7:0]  stim [0:maxLines*fields-1];
    int          numLines;
    int          errorCount;
    logic [31:0] seed;

    hangmanTop DUT (
        .clk           (clk),
        .nRst          (nRst),
        .wordLetter    (wordLetter),
        .wordLoad      (wordLoad),
        .startGame     (startGame),
        .guess         (guess),
        .guessValid    (guessValid),
        .gameReady     (gameReady),
        .busy          (busy),
        .revealed      (revealed),
        .numCorrect    (numCorrect),
        .numMistake    (numMistake),
        .hit           (hit),
        .mistake       (mistake),
        .guessRejected (guessRejected),
        .win           (win),
        .lose          (lose)
    );

    initial begin
        clk = 1'b0;
        forever #clkHalf clk = ~clk;
    end

    // ####################################################################
    // helpers
    // ####################################################################

    function automatic logic [31:0] nextRand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic checkEq(input string what, input int got, input int exp);
        assert (got == exp) else begin
            errorCount++;
            $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic checkStatus(input int expRev, input int expCorrect, input int expMistake,
                               input int expWin, input int expLose);
        checkEq("revealed", int'(revealed), expRev);
        checkEq("numCorrect", int'(numCorrect), expCorrect);
        checkEq("numMistake", int'(numMistake), expMistake);
        checkEq("win", int'(win), expWin);
        checkEq("lose", int'(lose), expLose);
        checkEq("busy", int'(busy), 0);
        checkEq("gameReady", int'(gameReady), int'(expWin == 0 && expLose == 0));
    endtask

    task automatic loadLetter(input hangmanPkg::letterT l);
        @(posedge clk);
        wordLetter <= l;
        wordLoad   <= 1'b1;
        @(posedge clk);
        wordLoad   <= 1'b0;
    endtask

    task automatic startRound();
        @(posedge clk);
        startGame <= 1'b1;
        @(posedge clk);
        startGame <= 1'b0;
        @(negedge clk);
        checkStatus(0, 0, 0, 0, 0); // a new round starts from a clean slate.
    endtask

    // sends one guess, waits for its outcome pulse and checks the timing and status.
    task automatic playGuess(input hangmanPkg::letterT l, input int expOutcome,
                             input bit noisy, input int expRev, input int expCorrect,
                             input int expMistake, input int expWin, input int expLose);
        int         cycles;
        logic [2:0] pulses;
        @(posedge clk);
        guess      <= l;
        guessValid <= 1'b1;
        @(posedge clk);     // the acceptance edge.
        guessValid <= 1'b0;
        cycles = 0;
        pulses = 3'b000;
        while (pulses == 3'b000) begin
            @(posedge clk);
            if (noisy) begin
                seed = nextRand(seed);
                guess      <= 8'h41 + 8'(seed[23:16] % 8'd26);
                guessValid <= (cycles < 4); // stops before decide hands back control.
            end
            @(negedge clk);
            cycles++;
            pulses = {hit, mistake, guessRejected};
            if (pulses == 3'b000) begin
                checkEq("busy while processing", int'(busy), 1);
            end
            if (cycles > 10) begin
                $display("no outcome pulse arrived after an accepted guess");
                $display("tests failed");
                $fatal(1, "missing outcome");
            end
        end
        checkEq("outcome latency", cycles, 6);
        checkEq("outcome pulses", int'(pulses), (expOutcome == 1) ? 4 :
                                                 (expOutcome == 2) ? 2 : 1);
        checkStatus(expRev, expCorrect, expMistake, expWin, expLose);
    endtask

    // a guess in won or lost must leave everything as it is.
    task automatic ignoredGuess(input hangmanPkg::letterT l, input int expRev,
                                input int expCorrect, input int expMistake,
                                input int expWin, input int expLose);
        @(posedge clk);
        guess      <= l;
        guessValid <= 1'b1;
        @(posedge clk);
        guessValid <= 1'b0;
        repeat (8) begin
            @(negedge clk);
            checkEq("outcome pulses", int'({hit, mistake, guessRejected}), 0);
        end
        checkStatus(expRev, expCorrect, expMistake, expWin, expLose);
    endtask

    // ####################################################################
    // watchdog
    // ####################################################################

    initial begin
        wait (numLines > 0);
        repeat ((numLines + 4) * 20) @(posedge clk);
        $display("timeout: the run did not finish in the expected number of cycles");
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    // ####################################################################
    // main sequence
    // ####################################################################

    initial begin
        int  base;
        int  cmd;
        bit  found;
        nRst       = 1'b0;
        wordLetter = '0;
        wordLoad   = 1'b0;
        startGame  = 1'b0;
        guess      = '0;
        guessValid = 1'b0;
        errorCount = 0;
        numLines   = 0;
        seed       = 32'h72c7c8dc;
        $readmemh("tb/hangman_stim.txt", stim);
        found = 0;
        for (int i = 0; i < maxLines && !found; i++) begin
            if (int'(stim[i*fields]) == cmdEnd) begin
                numLines = i + 1;
                found    = 1;
            end
        end
        if (!found) begin
            $display("the stimulus file has no end command");
            $display("tests failed");
            $fatal(1, "bad stimulus");
        end

        repeat (3) @(posedge clk);
        nRst <= 1'b1;
        @(negedge clk);
        checkStatus(0, 0, 0, 0, 0);
        checkEq("pulses after reset", int'({hit, mistake, guessRejected}), 0);

        for (int i = 0; i < numLines - 1; i++) begin
            base = i * fields;
            cmd  = int'(stim[base]);
            case (cmd)
                cmdLoad:   loadLetter(stim[base+1]);
                cmdStart:  startRound();
                cmdGuess, cmdNoisy: playGuess(stim[base+1], int'(stim[base+2]),
                                              cmd == cmdNoisy, int'(stim[base+3]),
                                              int'(stim[base+4]), int'(stim[base+5]),
                                              int'(stim[base+6]), int'(stim[base+7]));
                cmdIgnore: ignoredGuess(stim[base+1], int'(stim[base+3]),
                                        int'(stim[base+4]), int'(stim[base+5]),
                                        int'(stim[base+6]), int'(stim[base+7]));
                default: begin
                    $display("unknown command in the stimulus file");
                    $display("tests failed");
                    $fatal(1, "bad stimulus");
                end
            endcase
        end

        if (errorCount == 0 && DUT.uGameController.uProperties.failCount == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1, "errors found");
        end
    end

endmodule

/* tb/hangman_properties.sv */
// Concurrent checks on the game controller, bound into every gameController instance.

`timescale 1ns/1ns

module hangmanProperties (
    input logic                  clk,
    input logic                  nRst,
    input logic                  guessValid,
    input logic                  hit,
    input logic                  mistake,
    input logic                  guessRejected,
    input hangmanPkg::countT     numMistake,
    input logic                  busy,
    input logic                  gameReady,
    input hangmanPkg::gameStateT state
);

    int failCount = 0; // number of failed checks so far.

    // a guess resolves into exactly one kind of outcome.
    oneOutcome: assert property (@(posedge clk) disable iff (!nRst)
        $onehot0({hit, mistake, guessRejected}))
        else begin
            failCount++;
            $error("more than one outcome pulse in a cycle");
        end

    mistakeLimit: assert property (@(posedge clk) disable iff (!nRst)
        numMistake <= hangmanPkg::countT'(hangmanPkg::maxMistakes))
        else begin
            failCount++;
            $error("mistake counter above its limit");
        end

    busyNotReady: assert property (@(posedge clk) disable iff (!nRst)
        !(busy && gameReady))
        else begin
            failCount++;
            $error("busy and gameReady high together");
        end

    // an accepted guess settles six cycles later, whatever its outcome.
    outcomeLatency: assert property (@(posedge clk) disable iff (!nRst)
        (state == hangmanPkg::waitGuess && guessValid) |->
            ##7 (hit || mistake || guessRejected))
        else begin
            failCount++;
            $error("no outcome pulse six cycles after an accepted guess");
        end

endmodule

bind gameController hangmanProperties uProperties (
    .clk           (clk),
    .nRst          (nRst),
    .guessValid    (guessValid),
    .hit           (hit),
    .mistake       (mistake),
    .guessRejected (guessRejected),
    .numMistake    (numMistake),
    .busy          (busy),
    .gameReady     (gameReady),
    .state         (state)
);

/* tb/hangman_stim.txt */
// columns in hex: cmd letter outcome revealed numCorrect numMistake win lose
// cmd 0 load, 1 start, 2 guess, 3 guess with busy noise, 4 ignored guess, 0F end
// outcome 1 hit, 2 miss, 3 reject
00 41 00 00 00 00 00 00
00 50 00 00 00 00 00 00
00 50 00 00 00 00 00 00
00 4C 00 00 00 00 00 00
00 45 00 00 00 00 00 00
01 00 00 00 00 00 00 00
03 50 01 0C 02 00 00 00
02 50 03 0C 02 00 00 00
02 5A 02 0C 02 01 00 00
02 31 03 0C 02 01 00 00
02 41 01 1C 03 01 00 00
02 45 01 1D 04 01 00 00
02 4C 01 1F 05 01 01 00
04 58 00 1F 05 01 01 00
01 00 00 00 00 00 00 00
02 5A 02 00 00 01 00 00
02 42 02 00 00 02 00 00
02 43 02 00 00 03 00 00
02 44 02 00 00 04 00 00
02 46 02 00 00 05 00 00
02 47 02 00 00 06 00 01
04 41 00 00 00 06 00 01
01 00 00 00 00 00 00 00
02 5A 02 00 00 01 00 00
02 41 01 10 01 01 00 00
0F 00 00 00 00 00 00 00
